/* source/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_BITS = 5;     // 32-byte lines
    localparam int WAYS = 2;            // one lru bit per set only covers two ways

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [32*WORDS_PER_LINE-1:0] line_t;  // word k at bits 32k+31:32k

    // pick the instruction word of a line that pc points at
    function automatic inst_t word_of(line_t line, addr_t pc);
        return line[32*pc[OFFSET_BITS-1:2] +: 32];
    endfunction

endpackage

`default_nettype wire

/* source/fetch_lookup_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fetch_lookup_if
    import icache_pkg::*;
();

    logic  lookup_en;    // array read starts on this edge
    addr_t lookup_pc;
    logic  pair_valid;   // request sitting in compare
    addr_t pair_pc;
    logic  advance;      // compare slot frees up this cycle

    modport stage (
        output lookup_en,
        output lookup_pc,
        output pair_valid,
        output pair_pc,
        input  advance
    );

    modport core (
        input  lookup_en,
        input  lookup_pc,
        input  pair_valid,
        input  pair_pc,
        output advance
    );

endinterface

`default_nettype wire

/* source/inst_pair_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface inst_pair_if
    import icache_pkg::*;
();

    logic  valid;
    addr_t pc;
    inst_t inst0;   // word at pc
    inst_t inst1;   // word at pc+4
    logic  ready;

    modport core (
        output valid,
        output pc,
        output inst0,
        output inst1,
        input  ready
    );

    modport buffer (
        input  valid,
        input  pc,
        input  inst0,
        input  inst1,
        output ready
    );

endinterface

`default_nettype wire

/* source/fetch_request_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_request_stage
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  flush,
    input  logic  req_valid,
    input  addr_t req_pc,
    output logic  req_ready,
    fetch_lookup_if.stage lookup
);

    logic  out_of_reset;
    logic  accept;
    logic  held;
    addr_t held_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_of_reset <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;   // one dead cycle after reset
        end
    end

    // the core raises advance also when the compare slot is empty and it is idle
    assign req_ready = out_of_reset && !flush && lookup.advance;
    assign accept = req_valid && req_ready;

    assign lookup.lookup_en = accept;
    assign lookup.lookup_pc = req_pc;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            held <= 1'b0;
        end else if (accept) begin
            held <= 1'b1;
        end else if (lookup.advance) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_pc <= req_pc;
        end
    end

    assign lookup.pair_valid = held;
    assign lookup.pair_pc = held_pc;

endmodule

`default_nettype wire

/* source/icache_way_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_way_ram #(
    parameter int  ADDR_BITS = 7,
    parameter type entry_t = logic [31:0]
) (
    input  logic                 clk,
    input  logic [ADDR_BITS-1:0] rd_addr_a,
    input  logic [ADDR_BITS-1:0] rd_addr_b,
    input  logic                 rd_en,
    output entry_t               rd_data_a,
    output entry_t               rd_data_b,
    input  logic                 wr_en,
    input  logic [ADDR_BITS-1:0] wr_addr,
    input  entry_t               wr_data
);

    entry_t mem [2**ADDR_BITS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // outputs hold between lookups
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data_a <= mem[rd_addr_a];
            rd_data_b <= mem[rd_addr_b];
        end
    end

endmodule

`default_nettype wire

/* source/icache_core.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_core
    import icache_pkg::*;
#(
    parameter int SET_COUNT = 128
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  flush,
    fetch_lookup_if.core lookup,
    inst_pair_if.core    pair,
    output logic  rd_req,
    output addr_t rd_addr,
    input  logic  rd_ready,
    input  logic  ret_valid,
    input  line_t ret_data
);

    localparam int IDX_BITS = $clog2(SET_COUNT);
    localparam int TAG_BITS = 32 - OFFSET_BITS - IDX_BITS;

    typedef struct packed {
        logic                valid;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        S_IDLE, S_REQ_A, S_WAIT_A, S_REQ_B, S_WAIT_B, S_DELIVER
    } state_t;

    state_t state;
    logic need_b;       // pc+4 misses in a different line
    logic dropped;      // flushed while a refill is in flight
    inst_t inst0_q;
    inst_t inst1_q;
    addr_t lookup_pc_b;
    addr_t pc_b;
    addr_t fill_pc;
    logic [IDX_BITS-1:0] cmp_idx_a;
    logic [IDX_BITS-1:0] cmp_idx_b;
    logic [IDX_BITS-1:0] fill_idx;
    tag_entry_t fill_entry;
    tag_entry_t tag_a [WAYS];
    tag_entry_t tag_b [WAYS];
    line_t line_a [WAYS];
    line_t line_b [WAYS];
    logic [WAYS-1:0][SET_COUNT-1:0] valid_bits;
    logic [SET_COUNT-1:0] mru;  // way used last, per set
    logic [WAYS-1:0] hit_a;
    logic [WAYS-1:0] hit_b;
    logic [WAYS-1:0] fill_we;
    logic a_hit;
    logic b_hit;
    logic same_line;
    logic waiting;
    logic victim;
    logic compare_done;
    logic leave_idle;
    inst_t hit_inst0;
    inst_t hit_inst1;

    assign lookup_pc_b = lookup.lookup_pc + 32'd4;
    assign pc_b = lookup.pair_pc + 32'd4;
    assign cmp_idx_a = lookup.pair_pc[OFFSET_BITS +: IDX_BITS];
    assign cmp_idx_b = pc_b[OFFSET_BITS +: IDX_BITS];
    assign same_line = lookup.pair_pc[31:OFFSET_BITS] == pc_b[31:OFFSET_BITS];

    assign waiting = (state == S_WAIT_A) || (state == S_WAIT_B);
    assign fill_pc = (state == S_REQ_A || state == S_WAIT_A) ? lookup.pair_pc : pc_b;
    assign fill_idx = fill_pc[OFFSET_BITS +: IDX_BITS];
    assign fill_entry = '{valid: 1'b1, tag: fill_pc[31 -: TAG_BITS]};
    assign victim = !mru[fill_idx];

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic vld_a_q;  // reset-cleared valid copy, sampled with the read
        logic vld_b_q;

        icache_way_ram #(.ADDR_BITS(IDX_BITS), .entry_t(tag_entry_t)) i_tag_ram (
            .clk       (clk),
            .rd_addr_a (lookup.lookup_pc[OFFSET_BITS +: IDX_BITS]),
            .rd_addr_b (lookup_pc_b[OFFSET_BITS +: IDX_BITS]),
            .rd_en     (lookup.lookup_en),
            .rd_data_a (tag_a[w]),
            .rd_data_b (tag_b[w]),
            .wr_en     (fill_we[w]),
            .wr_addr   (fill_idx),
            .wr_data   (fill_entry)
        );

        icache_way_ram #(.ADDR_BITS(IDX_BITS), .entry_t(line_t)) i_data_ram (
            .clk       (clk),
            .rd_addr_a (lookup.lookup_pc[OFFSET_BITS +: IDX_BITS]),
            .rd_addr_b (lookup_pc_b[OFFSET_BITS +: IDX_BITS]),
            .rd_en     (lookup.lookup_en),
            .rd_data_a (line_a[w]),
            .rd_data_b (line_b[w]),
            .wr_en     (fill_we[w]),
            .wr_addr   (fill_idx),
            .wr_data   (ret_data)
        );

        always_ff @(posedge clk) begin
            if (lookup.lookup_en) begin
                vld_a_q <= valid_bits[w][lookup.lookup_pc[OFFSET_BITS +: IDX_BITS]];
                vld_b_q <= valid_bits[w][lookup_pc_b[OFFSET_BITS +: IDX_BITS]];
            end
        end

        assign hit_a[w] = vld_a_q && tag_a[w].valid
                          && tag_a[w].tag == lookup.pair_pc[31 -: TAG_BITS];
        assign hit_b[w] = vld_b_q && tag_b[w].valid && tag_b[w].tag == pc_b[31 -: TAG_BITS];
        assign fill_we[w] = ret_valid && waiting && (victim == 1'(w));
    end

    assign a_hit = |hit_a;
    assign b_hit = |hit_b;
    assign hit_inst0 = word_of(line_a[hit_a[1]], lookup.pair_pc);
    assign hit_inst1 = word_of(line_b[hit_b[1]], pc_b);

    assign compare_done = (state == S_IDLE) && lookup.pair_valid && a_hit && b_hit;
    assign leave_idle = (state == S_IDLE) && lookup.pair_valid && !flush
                        && (!(a_hit && b_hit) || pair.ready);

    assign pair.valid = compare_done || (state == S_DELIVER);
    assign pair.pc = lookup.pair_pc;
    assign pair.inst0 = (state == S_DELIVER) ? inst0_q : hit_inst0;
    assign pair.inst1 = (state == S_DELIVER) ? inst1_q : hit_inst1;

    assign lookup.advance = ((state == S_IDLE) && (!lookup.pair_valid || compare_done && pair.ready))
                            || ((state == S_DELIVER) && pair.ready);

    assign rd_req = (state == S_REQ_A) || (state == S_REQ_B);
    assign rd_addr = {fill_pc[31:OFFSET_BITS], OFFSET_BITS'(0)};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            need_b <= 1'b0;
            dropped <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (leave_idle && !(a_hit && b_hit)) begin
                        need_b <= !b_hit && !same_line;
                        state <= a_hit ? S_REQ_B : S_REQ_A;
                    end
                end
                S_REQ_A: if (rd_ready) state <= S_WAIT_A;
                S_REQ_B: if (rd_ready) state <= S_WAIT_B;
                S_WAIT_A: begin
                    if (ret_valid) begin
                        if (dropped || flush) state <= S_IDLE;
                        else state <= need_b ? S_REQ_B : S_DELIVER;
                    end
                end
                S_WAIT_B: begin
                    if (ret_valid) state <= (dropped || flush) ? S_IDLE : S_DELIVER;
                end
                S_DELIVER: if (flush || pair.ready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
            if (state == S_IDLE) begin
                dropped <= 1'b0;
            end else if (flush) begin
                dropped <= 1'b1;    // finish the refill, deliver nothing
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            inst0_q <= hit_inst0;
            inst1_q <= hit_inst1;
        end
        if (ret_valid && state == S_WAIT_A) begin
            inst0_q <= word_of(ret_data, lookup.pair_pc);
            if (same_line) inst1_q <= word_of(ret_data, pc_b);
        end
        if (ret_valid && state == S_WAIT_B) begin
            inst1_q <= word_of(ret_data, pc_b);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mru <= '1;  // way 0 gets the first fill
            valid_bits <= '0;
        end else begin
            if (leave_idle) begin
                if (a_hit) mru[cmp_idx_a] <= hit_a[1];
                if (b_hit) mru[cmp_idx_b] <= hit_b[1];
            end
            if (ret_valid && waiting) begin
                mru[fill_idx] <= victim;
                valid_bits[victim][fill_idx] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/inst_pair_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_pair_buffer
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  flush,
    inst_pair_if.buffer pair,
    output logic  out_valid,
    input  logic  out_ready,
    output addr_t out_pc,
    output inst_t out_inst0,
    output inst_t out_inst1
);

    addr_t pc_mem [2];
    inst_t inst0_mem [2];
    inst_t inst1_mem [2];
    logic wr_ptr;
    logic rd_ptr;
    logic [1:0] count;
    logic push;
    logic pop;

    assign pair.ready = count != 2'd2;
    assign push = pair.valid && pair.ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            count <= 2'd0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            if (push) wr_ptr <= !wr_ptr;
            if (pop) rd_ptr <= !rd_ptr;
            case ({push, pop})
                2'b10: count <= count + 2'd1;
                2'b01: count <= count - 2'd1;
                default: count <= count;   // none, or one in and one out
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr] <= pair.pc;
            inst0_mem[wr_ptr] <= pair.inst0;
            inst1_mem[wr_ptr] <= pair.inst1;
        end
    end

    assign out_valid = count != 2'd0;
    assign out_pc = pc_mem[rd_ptr];
    assign out_inst0 = inst0_mem[rd_ptr];
    assign out_inst1 = inst1_mem[rd_ptr];

endmodule

`default_nettype wire

/* source/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top
    import icache_pkg::*;
#(
    parameter int SET_COUNT = 128
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  flush,
    input  logic  req_valid,
    input  addr_t req_pc,
    output logic  req_ready,
    output logic  out_valid,
    input  logic  out_ready,
    output addr_t out_pc,
    output inst_t out_inst0,
    output inst_t out_inst1,
    output logic  rd_req,
    output addr_t rd_addr,
    input  logic  rd_ready,
    input  logic  ret_valid,
    input  line_t ret_data
);

    fetch_lookup_if lookup_bus ();
    inst_pair_if    pair_bus ();

    fetch_request_stage i_fetch_request_stage (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .req_valid (req_valid),
        .req_pc    (req_pc),
        .req_ready (req_ready),
        .lookup    (lookup_bus.stage)
    );

    icache_core #(.SET_COUNT(SET_COUNT)) i_icache_core (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .lookup    (lookup_bus.core),
        .pair      (pair_bus.core),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_ready  (rd_ready),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    inst_pair_buffer i_inst_pair_buffer (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .pair      (pair_bus.buffer),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pc    (out_pc),
        .out_inst0 (out_inst0),
        .out_inst1 (out_inst1)
    );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

/* test/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb
    import icache_pkg::*;
();

    localparam int SET_COUNT = 128;
    localparam int IDX_BITS = $clog2(SET_COUNT);
    localparam int TAG_W = 32 - OFFSET_BITS - IDX_BITS;
    localparam int NUM_REQ = 400;
    localparam int MAX_DELAY = 8;                                  // grant and return, cycles
    localparam int WORST_CYCLES = 2 * (2 * MAX_DELAY + 4) + 24;    // two refills plus a stall
    localparam int TIMEOUT_NS = NUM_REQ * WORST_CYCLES * 4 * 100;

    logic  clk;
    logic  reset = 1'b1;
    logic  flush = 1'b0;
    logic  req_valid = 1'b0;
    addr_t req_pc = '0;
    logic  req_ready;
    logic  out_valid;
    logic  out_ready = 1'b0;
    addr_t out_pc;
    inst_t out_inst0;
    inst_t out_inst1;
    logic  rd_req;
    addr_t rd_addr;
    logic  rd_ready = 1'b0;
    logic  ret_valid = 1'b0;
    line_t ret_data = '0;

    integer seed = 32'h3c8d_307d;
    int errors = 0;
    int sent = 0;
    int delivered = 0;
    int refills = 0;
    int flushes = 0;
    int stall_left = 0;
    int grant_cnt = 0;
    int ret_wait = 0;
    logic ret_pending = 1'b0;
    addr_t ret_line = '0;
    logic rd_acc = 1'b0;      // refill handshake on the coming edge
    logic rd_req_s = 1'b0;
    addr_t fill_addr = '0;

    logic [TAG_W-1:0] m_tag [WAYS][SET_COUNT];
    logic m_valid [WAYS][SET_COUNT];
    logic m_mru [SET_COUNT];
    addr_t pc_q [$];          // accepted, not yet delivered
    addr_t miss_q [$];        // refill lines still expected
    logic cur_busy = 1'b0;
    addr_t cur_pc = '0;
    addr_t pc_b;
    addr_t exp_val;
    int wa;
    int wb;

    tb_clock #(.PERIOD(100)) i_tb_clock (.clk(clk));

    icache_top #(.SET_COUNT(SET_COUNT)) i_icache_top (
        .clk(clk), .reset(reset), .flush(flush),
        .req_valid(req_valid), .req_pc(req_pc), .req_ready(req_ready),
        .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc),
        .out_inst0(out_inst0), .out_inst1(out_inst1),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_ready(rd_ready),
        .ret_valid(ret_valid), .ret_data(ret_data)
    );

    function automatic inst_t mem_word(addr_t a);
        return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]} ^ 32'h0f1e_2d3c;
    endfunction

    function automatic line_t make_line(addr_t base);
        line_t l;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            l[32*k +: 32] = mem_word(base + 32'(4 * k));
        end
        return l;
    endfunction

    // few tags over four neighbouring sets, so ways conflict and pairs cross lines
    function automatic addr_t pick_pc();
        logic [TAG_W-1:0] tag;
        logic [IDX_BITS-1:0] idx;
        logic [2:0] word;
        tag = TAG_W'(20'h12340) + TAG_W'($random(seed) & 3);
        idx = IDX_BITS'(32) + IDX_BITS'($random(seed) & 3);
        word = 3'($random(seed));
        return {tag, idx, word, 2'b00};
    endfunction

    function automatic int find_way(addr_t a);
        int idx;
        idx = int'(a[OFFSET_BITS +: IDX_BITS]);
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == a[31 -: TAG_W]) return w;
        end
        return -1;
    endfunction

    task automatic fill_line(addr_t a);
        int idx;
        int v;
        idx = int'(a[OFFSET_BITS +: IDX_BITS]);
        v = m_mru[idx] ? 0 : 1;    // victim is the way not used last
        m_tag[v][idx] = a[31 -: TAG_W];
        m_valid[v][idx] = 1'b1;
        m_mru[idx] = (v == 1);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // sampled mid-cycle, these are the handshakes of the coming edge
    always @(negedge clk) begin
        if (!reset) begin
            if (out_valid && out_ready) begin
                delivered++;
                if (pc_q.size() == 0) begin
                    $display("pair at pc %h delivered with no request pending", out_pc);
                    errors++;
                end else begin
                    exp_val = pc_q.pop_front();
                    check_value("out_pc", out_pc, exp_val);
                    check_value("out_inst0", out_inst0, mem_word(exp_val));
                    check_value("out_inst1", out_inst1, mem_word(exp_val + 32'd4));
                end
            end
            rd_acc = rd_req && rd_ready;
            if (rd_acc) begin
                refills++;
                fill_addr = rd_addr;
                if (miss_q.size() == 0) begin
                    $display("refill request for %h while no miss was expected", rd_addr);
                    errors++;
                end else begin
                    exp_val = miss_q.pop_front();
                    check_value("rd_addr", rd_addr, exp_val);
                end
            end
            if (ret_valid) fill_line(fill_addr);
            if (cur_busy) begin
                pc_b = cur_pc + 32'd4;
                wa = find_way(cur_pc);
                wb = find_way(pc_b);
                if (flush) begin
                    cur_busy = 1'b0;
                end else if (wa < 0 || wb < 0) begin
                    if (wa >= 0) m_mru[cur_pc[OFFSET_BITS +: IDX_BITS]] = (wa == 1);
                    if (wb >= 0) m_mru[pc_b[OFFSET_BITS +: IDX_BITS]] = (wb == 1);
                    if (wa < 0) miss_q.push_back({cur_pc[31:OFFSET_BITS], 5'd0});
                    if (wb < 0 && cur_pc[31:OFFSET_BITS] != pc_b[31:OFFSET_BITS]) begin
                        miss_q.push_back({pc_b[31:OFFSET_BITS], 5'd0});
                    end
                    cur_busy = 1'b0;
                end else if (req_ready) begin   // full hit leaves compare
                    m_mru[cur_pc[OFFSET_BITS +: IDX_BITS]] = (wa == 1);
                    m_mru[pc_b[OFFSET_BITS +: IDX_BITS]] = (wb == 1);
                    cur_busy = 1'b0;
                end
            end
            if (req_valid && req_ready) begin
                pc_q.push_back(req_pc);
                cur_pc = req_pc;
                cur_busy = 1'b1;
                sent++;
            end
            if (flush) begin
                flushes++;
                pc_q.delete();
                if (rd_req && !rd_ready) begin
                    while (miss_q.size() > 1) void'(miss_q.pop_back());   // pending request stays
                end else begin
                    miss_q.delete();
                end
            end
            if (pc_q.size() > 3) begin
                $display("more requests accepted than the buffer and compare stage hold");
                errors++;
            end
            rd_req_s = rd_req;
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            req_valid <= (sent < NUM_REQ) && (($random(seed) & 3) != 0);
            req_pc <= pick_pc();
            flush <= (sent < NUM_REQ) && (($random(seed) & 31) == 0);
            if (stall_left > 0) begin
                out_ready <= 1'b0;
                stall_left <= stall_left - 1;
            end else if (($random(seed) & 31) == 0) begin
                out_ready <= 1'b0;
                stall_left <= 6 + ($random(seed) & 15);   // long stall fills the buffer
            end else begin
                out_ready <= ($random(seed) & 3) != 0;
            end
        end
    end

    // memory side
    always @(posedge clk) begin
        if (!reset) begin
            ret_valid <= 1'b0;
            if (rd_acc) begin
                rd_ready <= 1'b0;
                ret_pending <= 1'b1;
                ret_wait <= $random(seed) & 7;
                ret_line <= fill_addr;
            end else if (ret_pending) begin
                if (ret_wait == 0) begin
                    ret_valid <= 1'b1;
                    ret_data <= make_line(ret_line);
                    ret_pending <= 1'b0;
                end else begin
                    ret_wait <= ret_wait - 1;
                end
            end else if (rd_req_s && !rd_ready) begin
                if (grant_cnt >= MAX_DELAY - 1 || ($random(seed) & 1) != 0) begin
                    rd_ready <= 1'b1;
                    grant_cnt <= 0;
                end else begin
                    grant_cnt <= grant_cnt + 1;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout, the requests did not finish in time");
        $display("requests %0d, delivered %0d, refills %0d, flushes %0d, errors %0d",
                 sent, delivered, refills, flushes, errors);
        $display("Checks failed");
        $finish;
    end

    initial begin
        for (int s = 0; s < SET_COUNT; s++) begin
            m_mru[s] = 1'b1;
            for (int w = 0; w < WAYS; w++) begin
                m_valid[w][s] = 1'b0;
                m_tag[w][s] = '0;
            end
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        wait (sent == NUM_REQ);
        @(posedge clk);
        while (pc_q.size() != 0 || miss_q.size() != 0 || ret_pending || rd_req_s || cur_busy) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("requests %0d, delivered %0d, refills %0d, flushes %0d, errors %0d",
                 sent, delivered, refills, flushes, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
source/icache_pkg.sv
source/fetch_lookup_if.sv
source/inst_pair_if.sv
source/fetch_request_stage.sv
source/icache_way_ram.sv
source/icache_core.sv
source/inst_pair_buffer.sv
source/icache_top.sv
test/tb_clock.sv
test/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the icache testbench with Verilator

LOG=sim.log

verilator --binary --timing -f files.f --top-module icache_tb -Mdir obj_dir -o icache_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/icache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi
exit 0
